// ==== tests/ex_input.txt ====
// op op1 op2 pc imm rd_data taken redirect_pc, all hex
// immediate forms use the register op with the immediate in op2
01 5 7 1000 20 c 0 1020
02 3 5 1000 20 fffffffffffffffe 0 1020
03 1 43 1000 20 8 0 1020
04 ffffffffffffffff 1 1000 20 1 0 1020
05 ffffffffffffffff 1 1000 20 0 0 1020
06 ff00 ff0 1000 20 f0f0 0 1020
07 8000000000000000 3f 1000 20 1 0 1020
08 8000000000000000 4 1000 20 f800000000000000 0 1020
09 f0 f 1000 20 ff 0 1020
0a f0 3c 1000 20 30 0 1020
0b 7fffffff 1 1000 20 ffffffff80000000 0 1020
0c 0 1 1000 20 ffffffffffffffff 0 1020
0d 1 1f 1000 20 ffffffff80000000 0 1020
0e ffffffff80000000 4 1000 20 8000000 0 1020
0f 80000000 4 1000 20 fffffffff8000000 0 1020
10 5 5 2000 fffffffffffffff0 0 1 1ff0
10 5 6 2000 fffffffffffffff0 0 0 1ff0
11 5 6 3000 100 0 1 3100
12 ffffffffffffffff 1 3000 100 0 1 3100
13 ffffffffffffffff 1 3000 100 0 0 3100
14 ffffffffffffffff 1 3000 100 0 0 3100
15 ffffffffffffffff 1 3000 100 0 1 3100
00 5 7 1000 20 0 0 1020
16 6 7 1000 20 2a 0 1020
16 6 7 1000 20 2a 0 1020
16 ffffffffffffffff 3 1000 20 fffffffffffffffd 0 1020
17 40000000 2 1000 20 ffffffff80000000 0 1020
17 ffffffff00000003 5 1000 20 f 0 1020
18 14 3 1000 20 6 0 1020
18 fffffffffffffff8 3 1000 20 fffffffffffffffe 0 1020
18 7 0 1000 20 ffffffffffffffff 0 1020
18 8000000000000000 ffffffffffffffff 1000 20 8000000000000000 0 1020
19 ffffffffffffffff 2 1000 20 7fffffffffffffff 0 1020
1a 14 3 1000 20 2 0 1020
1a fffffffffffffff8 3 1000 20 fffffffffffffffe 0 1020
1a 7 fffffffffffffffd 1000 20 1 0 1020
1a 7 0 1000 20 7 0 1020
1a 8000000000000000 ffffffffffffffff 1000 20 0 0 1020
1b ffffffffffffffff a 1000 20 5 0 1020

// ==== sim.f ====
verilog/ex_pkg.sv
verilog/muldiv_if.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/muldiv_seq.sv
verilog/mul_datapath.sv
verilog/div_datapath.sv
verilog/ex_stage.sv
tests/ex_checker.sv
tests/tb_ex_stage.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - verilog/ex_pkg.sv
  - verilog/muldiv_if.sv
  - verilog/alu.sv
  - verilog/branch_unit.sv
  - verilog/muldiv_seq.sv
  - verilog/mul_datapath.sv
  - verilog/div_datapath.sv
  - verilog/ex_stage.sv
  - target: test
    files:
      - tests/ex_checker.sv
      - tests/tb_ex_stage.sv

// ==== tests/tb_ex_stage.sv ====
/* execute stage testbench */
`default_nettype none

module tb_ex_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_VEC = 64;
    localparam int NUM_RANDOM = 100;
    localparam int WAIT_LIMIT = 200;

    logic          clk;
    logic          rst_i;
    logic          valid_i;
    ex_pkg::op_e   op_i;
    ex_pkg::xlen_t op1_i;
    ex_pkg::xlen_t op2_i;
    ex_pkg::xlen_t pc_i;
    ex_pkg::xlen_t imm_i;
    ex_pkg::xlen_t rd_data_o;
    logic          branch_taken_o;
    ex_pkg::xlen_t redirect_pc_o;
    logic          stall_req_o;
    logic          has_exp;
    ex_pkg::xlen_t exp_rd;
    logic          exp_taken;
    ex_pkg::xlen_t exp_redirect;
    int            test_cnt;
    int            pass_cnt;
    int            err_cnt;
    int            launched;
    int            n_vec;
    int            rnd_idx;
    bit            setup_err;
    bit            timed_out;
    logic [63:0]   vec_mem [0:MAX_VEC*8-1];
    logic [63:0]   lcg_state;
    ex_pkg::xlen_t ra;
    ex_pkg::xlen_t rb;

    ex_stage uut (
        .clk            (clk),
        .rst_i          (rst_i),
        .valid_i        (valid_i),
        .op_i           (op_i),
        .op1_i          (op1_i),
        .op2_i          (op2_i),
        .pc_i           (pc_i),
        .imm_i          (imm_i),
        .rd_data_o      (rd_data_o),
        .branch_taken_o (branch_taken_o),
        .redirect_pc_o  (redirect_pc_o),
        .stall_req_o    (stall_req_o)
    );

    ex_checker chk (
        .clk            (clk),
        .rst_i          (rst_i),
        .valid_i        (valid_i),
        .op_i           (op_i),
        .op1_i          (op1_i),
        .op2_i          (op2_i),
        .pc_i           (pc_i),
        .imm_i          (imm_i),
        .rd_data_i      (rd_data_o),
        .taken_i        (branch_taken_o),
        .redirect_i     (redirect_pc_o),
        .stall_i        (stall_req_o),
        .has_exp_i      (has_exp),
        .exp_rd_i       (exp_rd),
        .exp_taken_i    (exp_taken),
        .exp_redirect_i (exp_redirect),
        .test_cnt_o     (test_cnt),
        .pass_cnt_o     (pass_cnt),
        .err_cnt_o      (err_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [63:0] lcg_next(input logic [63:0] s);
        return s * 64'd6364136223846793005 + 64'd1442695040888963407;
    endfunction

    // drive one vector, then hold it until the stall drops
    task automatic apply_and_wait(
        input ex_pkg::op_e   op,
        input ex_pkg::xlen_t a,
        input ex_pkg::xlen_t b,
        input ex_pkg::xlen_t pc,
        input ex_pkg::xlen_t imm,
        input logic          use_exp,
        input ex_pkg::xlen_t erd,
        input logic          etaken,
        input ex_pkg::xlen_t eredir
    );
        int cycles;
        @(posedge clk);
        valid_i      <= 1'b1;
        op_i         <= op;
        op1_i        <= a;
        op2_i        <= b;
        pc_i         <= pc;
        imm_i        <= imm;
        has_exp      <= use_exp;
        exp_rd       <= erd;
        exp_taken    <= etaken;
        exp_redirect <= eredir;
        launched++;
        cycles = 0;
        @(negedge clk);
        while (stall_req_o && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (stall_req_o) begin
            $display("stall_req_o still high after %0d cycles on test %0d", cycles, launched);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        rst_i        = 1'b1;
        valid_i      = 1'b0;
        op_i         = ex_pkg::OP_BEQ;
        op1_i        = '0;
        op2_i        = '0;
        pc_i         = '0;
        imm_i        = '0;
        has_exp      = 1'b0;
        exp_rd       = '0;
        exp_taken    = 1'b0;
        exp_redirect = '0;
        launched     = 0;
        setup_err    = 1'b0;
        timed_out    = 1'b0;
        lcg_state    = 64'd9250;
        $readmemh("tests/ex_input.txt", vec_mem);
        repeat (3) @(posedge clk);
        rst_i <= 1'b0;
        // idle with an equal beq on the bus, no branch may be taken
        repeat (4) @(posedge clk);

        n_vec = 0;
        while (n_vec < MAX_VEC && !timed_out && !$isunknown(vec_mem[n_vec*8])) begin
            apply_and_wait(ex_pkg::op_e'(vec_mem[n_vec*8][4:0]), vec_mem[n_vec*8+1],
                           vec_mem[n_vec*8+2], vec_mem[n_vec*8+3], vec_mem[n_vec*8+4],
                           1'b1, vec_mem[n_vec*8+5], vec_mem[n_vec*8+6][0],
                           vec_mem[n_vec*8+7]);
            n_vec++;
        end
        if (n_vec == 0) begin
            $display("no vectors could be read from tests/ex_input.txt");
            setup_err = 1'b1;
        end

        // random alu and branch ops checked against the model
        for (rnd_idx = 0; rnd_idx < NUM_RANDOM && !timed_out; rnd_idx++) begin
            lcg_state = lcg_next(lcg_state);
            ra = lcg_state;
            lcg_state = lcg_next(lcg_state);
            rb = lcg_state;
            if (rb[2:0] == 3'd0) begin
                rb = ra;
            end
            lcg_state = lcg_next(lcg_state);
            apply_and_wait(ex_pkg::op_e'(5'd1 + 5'(lcg_state[63:40] % 21)), ra, rb,
                           {32'd0, lcg_state[39:10], 2'b00},
                           {{52{lcg_state[51]}}, lcg_state[51:40]},
                           1'b0, '0, 1'b0, '0);
        end

        @(posedge clk);
        valid_i <= 1'b0;
        has_exp <= 1'b0;
        // an all-ones or must not reach rd_data_o while idle
        op_i    <= ex_pkg::OP_OR;
        op1_i   <= '1;
        repeat (3) @(posedge clk);
        if (test_cnt != launched) begin
            $display("checker counted %0d tests but %0d were applied", test_cnt, launched);
        end
        $display("tests %0d, passed %0d, errors %0d", test_cnt, pass_cnt, err_cnt);
        if (!setup_err && !timed_out && err_cnt == 0 && test_cnt == launched) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/ex_checker.sv ====
/* execute stage result checker */
`default_nettype none

module ex_checker (
    input  logic          clk,
    input  logic          rst_i,
    input  logic          valid_i,
    input  ex_pkg::op_e   op_i,
    input  ex_pkg::xlen_t op1_i,
    input  ex_pkg::xlen_t op2_i,
    input  ex_pkg::xlen_t pc_i,
    input  ex_pkg::xlen_t imm_i,
    input  ex_pkg::xlen_t rd_data_i,
    input  logic          taken_i,
    input  ex_pkg::xlen_t redirect_i,
    input  logic          stall_i,
    input  logic          has_exp_i,
    input  ex_pkg::xlen_t exp_rd_i,
    input  logic          exp_taken_i,
    input  ex_pkg::xlen_t exp_redirect_i,
    output int            test_cnt_o,
    output int            pass_cnt_o,
    output int            err_cnt_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int            stall_cnt;
    int            exp_stall;
    logic          iter_op;
    ex_pkg::xlen_t want_rd;
    logic          want_taken;

    function automatic ex_pkg::xlen_t sext32(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    // branches and OP_NONE write nothing, so zero
    function automatic ex_pkg::xlen_t model_rd(
        input ex_pkg::op_e op, input ex_pkg::xlen_t a, input ex_pkg::xlen_t b);
        case (op)
            ex_pkg::OP_ADD:  return a + b;
            ex_pkg::OP_SUB:  return a - b;
            ex_pkg::OP_SLL:  return a << b[5:0];
            ex_pkg::OP_SLT:  return {63'd0, $signed(a) < $signed(b)};
            ex_pkg::OP_SLTU: return {63'd0, a < b};
            ex_pkg::OP_XOR:  return a ^ b;
            ex_pkg::OP_SRL:  return a >> b[5:0];
            ex_pkg::OP_SRA:  return $signed(a) >>> b[5:0];
            ex_pkg::OP_OR:   return a | b;
            ex_pkg::OP_AND:  return a & b;
            ex_pkg::OP_ADDW: return sext32(a[31:0] + b[31:0]);
            ex_pkg::OP_SUBW: return sext32(a[31:0] - b[31:0]);
            ex_pkg::OP_SLLW: return sext32(a[31:0] << b[4:0]);
            ex_pkg::OP_SRLW: return sext32(a[31:0] >> b[4:0]);
            ex_pkg::OP_SRAW: return sext32($signed(a[31:0]) >>> b[4:0]);
            default:         return '0;
        endcase
    endfunction

    function automatic logic model_taken(
        input ex_pkg::op_e op, input ex_pkg::xlen_t a, input ex_pkg::xlen_t b);
        case (op)
            ex_pkg::OP_BEQ:  return a == b;
            ex_pkg::OP_BNE:  return a != b;
            ex_pkg::OP_BLT:  return $signed(a) < $signed(b);
            ex_pkg::OP_BGE:  return $signed(a) >= $signed(b);
            ex_pkg::OP_BLTU: return a < b;
            ex_pkg::OP_BGEU: return a >= b;
            default:         return 1'b0;
        endcase
    endfunction

    initial begin
        test_cnt_o = 0;
        pass_cnt_o = 0;
        err_cnt_o  = 0;
        stall_cnt  = 0;
    end

    always @(negedge clk) begin
        if (rst_i) begin
            stall_cnt = 0;
        end else if (!valid_i) begin
            if (stall_i || taken_i || rd_data_i !== '0) begin
                err_cnt_o++;
                $display("Fail %0t: idle outputs active, rd %h br %b stall %b",
                         $time, rd_data_i, taken_i, stall_i);
            end
        end else if (stall_i) begin
            stall_cnt++;
        end else begin
            iter_op = (op_i == ex_pkg::OP_MUL) || (op_i == ex_pkg::OP_MULW) ||
                      (op_i == ex_pkg::OP_DIV) || (op_i == ex_pkg::OP_DIVU) ||
                      (op_i == ex_pkg::OP_REM) || (op_i == ex_pkg::OP_REMU);
            exp_stall  = iter_op ? ex_pkg::MUL_STEPS + 1 : 0;
            want_rd    = has_exp_i ? exp_rd_i : model_rd(op_i, op1_i, op2_i);
            want_taken = has_exp_i ? exp_taken_i : model_taken(op_i, op1_i, op2_i);
            test_cnt_o++;
            if (rd_data_i === want_rd && taken_i === want_taken &&
                redirect_i === pc_i + imm_i && (!has_exp_i || redirect_i === exp_redirect_i) &&
                stall_cnt == exp_stall) begin
                pass_cnt_o++;
                $display("test %0d op %0h ok", test_cnt_o, op_i);
            end else begin
                err_cnt_o++;
                // got/expected pairs
                $display("Fail %0t: test %0d op %0h rd %h/%h br %b/%b pc %h/%h stall %0d/%0d",
                         $time, test_cnt_o, op_i, rd_data_i, want_rd, taken_i, want_taken,
                         redirect_i, pc_i + imm_i, stall_cnt, exp_stall);
            end
            stall_cnt = 0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ex_stage.sv ====
/* integer execute stage */
`default_nettype none

module ex_stage (
    input  logic          clk,
    input  logic          rst_i,
    input  logic          valid_i,
    input  ex_pkg::op_e   op_i,
    input  ex_pkg::xlen_t op1_i,
    input  ex_pkg::xlen_t op2_i,
    input  ex_pkg::xlen_t pc_i,
    input  ex_pkg::xlen_t imm_i,
    output ex_pkg::xlen_t rd_data_o,
    output logic          branch_taken_o,
    output ex_pkg::xlen_t redirect_pc_o,
    output logic          stall_req_o
);

    ex_pkg::md_kind_e md_kind;
    logic             md_signed;
    logic             is_mulw;
    logic             br_taken;
    logic             busy;
    ex_pkg::xlen_t    br_target;
    ex_pkg::xlen_t    alu_res;
    ex_pkg::xlen_t    product;
    ex_pkg::xlen_t    word_prod;
    ex_pkg::xlen_t    quotient;
    ex_pkg::xlen_t    remainder;
    ex_pkg::xlen_t    md_res;

    muldiv_if md_bus ();

    always_comb begin
        md_kind   = ex_pkg::MD_NONE;
        md_signed = 1'b0;
        case (op_i)
            ex_pkg::OP_MUL, ex_pkg::OP_MULW: begin
                md_kind = ex_pkg::MD_MUL;
            end
            ex_pkg::OP_DIV, ex_pkg::OP_REM: begin
                md_kind   = ex_pkg::MD_DIV;
                md_signed = 1'b1;
            end
            ex_pkg::OP_DIVU, ex_pkg::OP_REMU: begin
                md_kind = ex_pkg::MD_DIV;
            end
            default: begin
                md_kind = ex_pkg::MD_NONE;
            end
        endcase
    end

    // mulw only needs the low word of each operand
    assign is_mulw = op_i == ex_pkg::OP_MULW;
    assign md_bus.signed_op = md_signed;
    assign md_bus.op_a = is_mulw ?
        {{(ex_pkg::XLEN - ex_pkg::XLEN_W){1'b0}}, op1_i[ex_pkg::XLEN_W-1:0]} : op1_i;
    assign md_bus.op_b = is_mulw ?
        {{(ex_pkg::XLEN - ex_pkg::XLEN_W){1'b0}}, op2_i[ex_pkg::XLEN_W-1:0]} : op2_i;

    alu u_alu (
        .op_i     (op_i),
        .op1_i    (op1_i),
        .op2_i    (op2_i),
        .result_o (alu_res)
    );

    branch_unit u_branch (
        .op_i     (op_i),
        .op1_i    (op1_i),
        .op2_i    (op2_i),
        .pc_i     (pc_i),
        .imm_i    (imm_i),
        .taken_o  (br_taken),
        .target_o (br_target)
    );

    muldiv_seq u_seq (
        .clk     (clk),
        .rst_i   (rst_i),
        .start_i (valid_i),
        .kind_i  (md_kind),
        .busy_o  (busy),
        .ctl     (md_bus.seq)
    );

    mul_datapath u_mul (
        .clk       (clk),
        .md        (md_bus.dp),
        .product_o (product)
    );

    div_datapath u_div (
        .clk         (clk),
        .md          (md_bus.dp),
        .quotient_o  (quotient),
        .remainder_o (remainder)
    );

    assign word_prod = {{(ex_pkg::XLEN - ex_pkg::XLEN_W){product[ex_pkg::XLEN_W-1]}},
                        product[ex_pkg::XLEN_W-1:0]};

    // iterative result only counts in the done cycle
    always_comb begin
        md_res = '0;
        if (md_bus.done) begin
            case (op_i)
                ex_pkg::OP_MUL:                   md_res = product;
                ex_pkg::OP_MULW:                  md_res = word_prod;
                ex_pkg::OP_DIV, ex_pkg::OP_DIVU:  md_res = quotient;
                ex_pkg::OP_REM, ex_pkg::OP_REMU:  md_res = remainder;
                default:                          md_res = '0;
            endcase
        end
    end

    assign rd_data_o = !valid_i ? '0 :
                       (md_kind != ex_pkg::MD_NONE) ? md_res : alu_res;

    assign branch_taken_o = valid_i && br_taken;
    assign redirect_pc_o  = br_target;
    assign stall_req_o    = busy;

    op_held_in_stall: assert property (
        @(posedge clk) disable iff (rst_i) stall_req_o |=> $stable(op_i)
    );

endmodule

`default_nettype wire

// ==== verilog/div_datapath.sv ====
/* restoring divider */
`default_nettype none

module div_datapath (
    input  logic          clk,
    muldiv_if.dp          md,
    output ex_pkg::xlen_t quotient_o,
    output ex_pkg::xlen_t remainder_o
);

    ex_pkg::xlen_t         quo_q;
    ex_pkg::xlen_t         rem_q;
    ex_pkg::xlen_t         dvsr_q;
    ex_pkg::xlen_t         dividend_q;
    logic                  q_neg_q;
    logic                  r_neg_q;
    logic                  div_zero_q;
    logic                  a_neg;
    logic                  b_neg;
    ex_pkg::xlen_t         a_abs;
    ex_pkg::xlen_t         b_abs;
    logic [ex_pkg::XLEN:0] shifted;
    logic [ex_pkg::XLEN:0] trial;

    assign a_neg = md.signed_op && md.op_a[ex_pkg::XLEN-1];
    assign b_neg = md.signed_op && md.op_b[ex_pkg::XLEN-1];
    assign a_abs = a_neg ? -md.op_a : md.op_a;
    assign b_abs = b_neg ? -md.op_b : md.op_b;

    // partial remainder picks up the next dividend bit
    assign shifted = {rem_q, quo_q[ex_pkg::XLEN-1]};
    assign trial   = shifted - {1'b0, dvsr_q};

    always_ff @(posedge clk) begin
        if (md.load) begin
            quo_q      <= a_abs;
            rem_q      <= '0;
            dvsr_q     <= b_abs;
            dividend_q <= md.op_a;
            q_neg_q    <= a_neg ^ b_neg;
            r_neg_q    <= a_neg;
            div_zero_q <= md.op_b == '0;
        end else if (md.step) begin
            if (!trial[ex_pkg::XLEN]) begin
                rem_q <= trial[ex_pkg::XLEN-1:0];
                quo_q <= {quo_q[ex_pkg::XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[ex_pkg::XLEN-1:0];
                quo_q <= {quo_q[ex_pkg::XLEN-2:0], 1'b0};
            end
        end
    end

    // most negative over -1 wraps back to the dividend with zero remainder
    assign quotient_o  = div_zero_q ? '1 : (q_neg_q ? -quo_q : quo_q);
    assign remainder_o = div_zero_q ? dividend_q : (r_neg_q ? -rem_q : rem_q);

    no_load_during_step: assert property (
        @(posedge clk) md.load |-> !md.step
    );

endmodule

`default_nettype wire

// ==== verilog/mul_datapath.sv ====
/* shift-add multiplier */
`default_nettype none

module mul_datapath (
    input  logic          clk,
    muldiv_if.dp          md,
    output ex_pkg::xlen_t product_o
);

    ex_pkg::xlen_t acc_q;
    ex_pkg::xlen_t mcand_q;
    ex_pkg::xlen_t mplier_q;

    // low half of the product is the same for signed and unsigned
    always_ff @(posedge clk) begin
        if (md.load) begin
            acc_q    <= '0;
            mcand_q  <= md.op_a;
            mplier_q <= md.op_b;
        end else if (md.step) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign product_o = acc_q;

endmodule

`default_nettype wire

// ==== verilog/muldiv_seq.sv ====
/* multiply and divide sequencer */
`default_nettype none

module muldiv_seq (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             start_i,
    input  ex_pkg::md_kind_e kind_i,
    output logic             busy_o,
    muldiv_if.seq            ctl
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_e;

    state_e                    state_q;
    logic [ex_pkg::STEP_W-1:0] cnt_q;
    logic                      go;
    logic                      last_step;

    // only iterative ops start the unit
    assign go        = start_i && (kind_i != ex_pkg::MD_NONE);
    assign last_step = cnt_q == (ex_pkg::MUL_STEPS - 1);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (go) begin
                        state_q <= RUN;
                        cnt_q   <= '0;
                    end
                end
                RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_step) begin
                        state_q <= DONE;
                    end
                end
                // result cycle, stall already released
                DONE:    state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    assign ctl.load = (state_q == IDLE) && go;
    assign ctl.step = state_q == RUN;
    assign ctl.done = state_q == DONE;

    assign busy_o = ((state_q == IDLE) && go) || (state_q == RUN);

    cnt_in_range: assert property (
        @(posedge clk) disable iff (rst_i) cnt_q <= ex_pkg::MUL_STEPS
    );

endmodule

`default_nettype wire

// ==== verilog/branch_unit.sv ====
/* branch resolution */
`default_nettype none

module branch_unit (
    input  ex_pkg::op_e   op_i,
    input  ex_pkg::xlen_t op1_i,
    input  ex_pkg::xlen_t op2_i,
    input  ex_pkg::xlen_t pc_i,
    input  ex_pkg::xlen_t imm_i,
    output logic          taken_o,
    output ex_pkg::xlen_t target_o
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = op1_i == op2_i;
    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;

    always_comb begin
        case (op_i)
            ex_pkg::OP_BEQ:  taken_o = eq;
            ex_pkg::OP_BNE:  taken_o = !eq;
            ex_pkg::OP_BLT:  taken_o = lt_s;
            ex_pkg::OP_BGE:  taken_o = !lt_s;
            ex_pkg::OP_BLTU: taken_o = lt_u;
            ex_pkg::OP_BGEU: taken_o = !lt_u;
            default:         taken_o = 1'b0;
        endcase
    end

    assign target_o = pc_i + imm_i;

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
/* single-cycle integer alu */
`default_nettype none

module alu (
    input  ex_pkg::op_e   op_i,
    input  ex_pkg::xlen_t op1_i,
    input  ex_pkg::xlen_t op2_i,
    output ex_pkg::xlen_t result_o
);

    logic [ex_pkg::SHAMT_W-1:0]        shamt;
    logic [$clog2(ex_pkg::XLEN_W)-1:0] shamt_w;
    logic [ex_pkg::XLEN_W-1:0]         op1_w;
    logic [ex_pkg::XLEN_W-1:0]         sll_w;
    logic [ex_pkg::XLEN_W-1:0]         srl_w;
    logic [ex_pkg::XLEN_W-1:0]         sra_w;
    ex_pkg::xlen_t                     sum;
    ex_pkg::xlen_t                     diff;
    ex_pkg::xlen_t                     sra_res;

    function automatic ex_pkg::xlen_t sext_word(input logic [ex_pkg::XLEN_W-1:0] w);
        sext_word = {{(ex_pkg::XLEN - ex_pkg::XLEN_W){w[ex_pkg::XLEN_W-1]}}, w};
    endfunction

    assign shamt   = op2_i[ex_pkg::SHAMT_W-1:0];
    assign shamt_w = op2_i[$clog2(ex_pkg::XLEN_W)-1:0];
    assign op1_w   = op1_i[ex_pkg::XLEN_W-1:0];

    assign sum     = op1_i + op2_i;
    assign diff    = op1_i - op2_i;
    assign sra_res = $signed(op1_i) >>> shamt;

    // word shifts only see the low half of op1
    assign sll_w = op1_w << shamt_w;
    assign srl_w = op1_w >> shamt_w;
    assign sra_w = $signed(op1_w) >>> shamt_w;

    always_comb begin
        case (op_i)
            ex_pkg::OP_ADD:  result_o = sum;
            ex_pkg::OP_SUB:  result_o = diff;
            ex_pkg::OP_SLL:  result_o = op1_i << shamt;
            ex_pkg::OP_SLT:  result_o = ex_pkg::xlen_t'($signed(op1_i) < $signed(op2_i));
            ex_pkg::OP_SLTU: result_o = ex_pkg::xlen_t'(op1_i < op2_i);
            ex_pkg::OP_XOR:  result_o = op1_i ^ op2_i;
            ex_pkg::OP_SRL:  result_o = op1_i >> shamt;
            ex_pkg::OP_SRA:  result_o = sra_res;
            ex_pkg::OP_OR:   result_o = op1_i | op2_i;
            ex_pkg::OP_AND:  result_o = op1_i & op2_i;
            ex_pkg::OP_ADDW: result_o = sext_word(sum[ex_pkg::XLEN_W-1:0]);
            ex_pkg::OP_SUBW: result_o = sext_word(diff[ex_pkg::XLEN_W-1:0]);
            ex_pkg::OP_SLLW: result_o = sext_word(sll_w);
            ex_pkg::OP_SRLW: result_o = sext_word(srl_w);
            ex_pkg::OP_SRAW: result_o = sext_word(sra_w);
            default:         result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/muldiv_if.sv ====
/* multiply and divide control bus */
`default_nettype none

interface muldiv_if;

    logic          load;
    logic          step;
    logic          signed_op;
    ex_pkg::xlen_t op_a;
    ex_pkg::xlen_t op_b;
    logic          done;

    // operand fields are driven from the stage top
    modport seq (
        output load,
        output step,
        output done,
        output signed_op,
        output op_a,
        output op_b
    );

    modport dp (
        input load,
        input step,
        input done,
        input signed_op,
        input op_a,
        input op_b
    );

endinterface

`default_nettype wire

// ==== verilog/ex_pkg.sv ====
/* execute stage shared definitions */
`default_nettype none

package ex_pkg;

    localparam int unsigned XLEN = 64;
    localparam int unsigned XLEN_W = 32;
    localparam int unsigned SHAMT_W = 6;

    // iterative unit, one bit per step
    localparam int unsigned STEP_W = 7;
    localparam int unsigned MUL_STEPS = XLEN;

    typedef logic [XLEN-1:0] xlen_t;

    // register and immediate forms share one op, op2 carries the immediate
    typedef enum logic [4:0] {
        OP_NONE,
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_ADDW,
        OP_SUBW,
        OP_SLLW,
        OP_SRLW,
        OP_SRAW,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_MUL,
        OP_MULW,
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU
    } op_e;

    typedef enum logic [1:0] {
        MD_NONE,
        MD_MUL,
        MD_DIV
    } md_kind_e;

endpackage

`default_nettype wire
